//--- filelist.f
simple_system_pkg.sv
dev_bus_if.sv
bus_decode.sv
ram_1p.sv
sim_ctrl.sv
timer.sv
simple_system.sv
tb_simple_system.sv

//--- Bender.yml
package:
  name: simple_system

sources:
  - simple_system_pkg.sv
  - dev_bus_if.sv
  - bus_decode.sv
  - ram_1p.sv
  - sim_ctrl.sv
  - timer.sv
  - simple_system.sv
  - target: test
    files:
      - tb_simple_system.sv

//--- tb_simple_system.sv
/*
 * Simple system testbench
 * Drives the host data port and checks RAM, decoder errors, sim control and timer
 */
module tb_simple_system;

  import simple_system_pkg::*;

  localparam int unsigned clk_period   = 20;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned nr_words     = 16;
  localparam int unsigned nr_partial   = 8;
  localparam int unsigned timer_wait   = 40;
  localparam int unsigned planned_accesses =
    2 * nr_words + nr_partial + (2 + nr_words) + 4 + 6 + 4 + (1 + nr_words);
  localparam int unsigned watchdog_cycles =
    reset_cycles + (planned_accesses + timer_wait) * 4;
  localparam logic [addr_width-1:0] unmapped_base = 32'h0005_0000;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  host_req_i;
  logic                  host_gnt_o;
  logic [addr_width-1:0] host_addr_i;
  logic                  host_we_i;
  logic [be_width-1:0]   host_be_i;
  logic [data_width-1:0] host_wdata_i;
  logic                  host_rvalid_o;
  logic [data_width-1:0] host_rdata_o;
  logic                  host_err_o;
  logic                  timer_irq_o;
  logic                  char_valid_o;
  logic [7:0]            char_o;
  logic                  halt_o;
  logic                  char_write;

  integer                seed = 32'h4b6e_016f;
  int unsigned           cycle_cnt = 0;
  int unsigned           req_cycle;
  int unsigned           char_cnt = 0;
  logic [data_width-1:0] model [ram_depth];
  int unsigned           word_list [nr_words];

  simple_system dut0 (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .timer_irq_o   (timer_irq_o),
    .char_valid_o  (char_valid_o),
    .char_o        (char_o),
    .halt_o        (halt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Strobe is stable at the falling edge
  always @(negedge clk_i) begin
    if (char_valid_o) begin
      char_cnt <= char_cnt + 1;
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Watchdog expired, the bus accesses did not finish in time");
    $display("Test FAILED");
    $fatal(1, "run aborted by watchdog");
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] apply_byte_enables(logic [31:0] old_w, logic [31:0] new_w,
                                                      logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] ram_addr(int unsigned idx);
    return ram_base + 32'(idx * 4);
  endfunction

  function automatic logic [31:0] timer_addr(logic [dev_off_width-1:0] off);
    return timer_base | 32'(off);
  endfunction

  function automatic logic [31:0] sim_ctrl_addr(logic [dev_off_width-1:0] off);
    return sim_ctrl_base | 32'(off);
  endfunction

  assign char_write = host_req_i && host_we_i && host_be_i[0] &&
                      (host_addr_i == sim_ctrl_addr(sim_ctrl_char_off));

  gnt_eq_req: assert property (@(posedge clk_i) host_gnt_o == host_req_i)
    else report_mismatch("host_gnt_o", $sampled(host_req_i), $sampled(host_gnt_o));

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rvalid_o == $past(host_req_i && host_gnt_o))
    else report_mismatch("host_rvalid_o", !$sampled(host_rvalid_o), $sampled(host_rvalid_o));

  char_after_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    char_valid_o == $past(char_write))
    else report_mismatch("char_valid_o", !$sampled(char_valid_o), $sampled(char_valid_o));

  halt_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(halt_o) |-> halt_o)
    else report_mismatch("halt_o", 1, $sampled(halt_o));

  // One request cycle, then the response cycle
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_i);
    #2;
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_be_i    = be;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    req_cycle    = cycle_cnt;
    #1;
    assert (host_gnt_o === 1'b1) else report_mismatch("host_gnt_o", 1, host_gnt_o);
    @(posedge clk_i);
    #1;
    assert (host_rvalid_o === 1'b1) else report_mismatch("host_rvalid_o", 1, host_rvalid_o);
    rdata = host_rdata_o;
    err   = host_err_o;
    #1;
    host_req_i = 1'b0;
    host_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, output logic err);
    logic [31:0] unused_rdata;
    bus_access(1'b1, addr, be, wdata, unused_rdata, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    bus_access(1'b0, addr, 4'hF, 32'h0, rdata, err);
  endtask

  task automatic write_ok(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] data);
    logic err;
    bus_write(addr, be, data, err);
    assert (err === 1'b0) else report_mismatch("host_err_o", 0, err);
  endtask

  task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_read(addr, data, err);
    assert (err === 1'b0) else report_mismatch("host_err_o", 0, err);
  endtask

  task automatic check_read(input logic [31:0] addr, input logic [31:0] expected,
                            input string name);
    logic [31:0] data;
    read_ok(addr, data);
    assert (data === expected) else report_mismatch(name, expected, data);
  endtask

  task automatic check_ram_contents();
    for (int i = 0; i < nr_words; i++) begin
      check_read(ram_addr(word_list[i]), model[word_list[i]], "host_rdata_o");
    end
  endtask

  task automatic write_char(input logic [7:0] c);
    write_ok(sim_ctrl_addr(sim_ctrl_char_off), 4'h1, {24'h0, c});
    assert (char_valid_o === 1'b1) else report_mismatch("char_valid_o", 1, char_valid_o);
    assert (char_o === c) else report_mismatch("char_o", c, char_o);
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] t_hi;
    int unsigned c0;
    int unsigned c1;
    logic [63:0] target;
    logic [63:0] now;
    logic [3:0]  be;
    logic [31:0] data;
    int unsigned idx;
    bit          used [ram_depth];
    logic        irq_seen;
    string       text;

    arst_n_i     = 1'b0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    repeat (reset_cycles) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    #1;
    assert (!host_rvalid_o && !host_err_o && !char_valid_o && !halt_o && !timer_irq_o)
      else report_failure("an output is not low after reset");

    // RAM round trip, full words then partial byte enables
    for (int i = 0; i < nr_words; i++) begin
      idx = $unsigned($random(seed)) % ram_depth;
      while (used[idx]) begin
        idx = $unsigned($random(seed)) % ram_depth;
      end
      used[idx]    = 1'b1;
      word_list[i] = idx;
      data         = $random(seed);
      model[idx]   = data;
      write_ok(ram_addr(idx), 4'hF, data);
    end
    for (int i = 0; i < nr_partial; i++) begin
      idx  = word_list[i];
      data = $random(seed);
      be   = $random(seed);
      if (be == 4'h0 || be == 4'hF) begin
        be = 4'h6;
      end
      model[idx] = apply_byte_enables(model[idx], data, be);
      write_ok(ram_addr(idx), be, data);
    end
    check_ram_contents();

    // Unmapped window, low bits aliasing a used RAM word
    bus_read(unmapped_base + 32'(word_list[0] * 4), rdata, err);
    assert (err === 1'b1) else report_mismatch("host_err_o", 1, err);
    assert (rdata === 32'h0) else report_mismatch("host_rdata_o", 0, rdata);
    bus_write(unmapped_base + 32'(word_list[0] * 4), 4'hF, ~model[word_list[0]], err);
    assert (err === 1'b1) else report_mismatch("host_err_o", 1, err);
    // Still inside the response cycle of the write
    assert (host_rdata_o === 32'h0) else report_mismatch("host_rdata_o", 0, host_rdata_o);
    check_ram_contents();

    // Character output
    text = "OK\n";
    for (int i = 0; i < text.len(); i++) begin
      write_char(text[i]);
    end
    write_ok(sim_ctrl_addr(sim_ctrl_char_off), 4'hE, 32'h58);
    repeat (2) @(posedge clk_i);
    #1;
    assert (char_cnt == text.len()) else report_mismatch("char_valid_o pulses", 3, char_cnt);

    // Timer step, compare and interrupt
    read_ok(timer_addr(timer_reg_mtime_lo), t0);
    c0 = req_cycle;
    repeat (3) @(posedge clk_i);
    read_ok(timer_addr(timer_reg_mtime_lo), t1);
    c1 = req_cycle;
    assert (t1 - t0 == c1 - c0) else report_mismatch("mtime_lo step", c1 - c0, t1 - t0);
    read_ok(timer_addr(timer_reg_mtime_hi), t_hi);
    target = {t_hi, t1} + 64'd20;
    write_ok(timer_addr(timer_reg_mtimecmp_hi), 4'hF, target[63:32]);
    write_ok(timer_addr(timer_reg_mtimecmp_lo), 4'hF, target[31:0]);
    irq_seen = 1'b0;
    for (int n = 0; n < timer_wait && !irq_seen; n++) begin
      @(posedge clk_i);
      #1;
      // Interrupt reflects mtime of the previous cycle
      now = {t_hi, t1} + 64'(cycle_cnt - 1 - c1);
      assert (timer_irq_o === (now >= target))
        else report_mismatch("timer_irq_o", now >= target, timer_irq_o);
      irq_seen = timer_irq_o;
    end
    if (!irq_seen) begin
      report_failure("timer interrupt did not rise after mtime reached mtimecmp");
    end
    write_ok(timer_addr(timer_reg_mtimecmp_hi), 4'hF, 32'hFFFF_FFFF);
    @(posedge clk_i);
    #1;
    assert (timer_irq_o === 1'b0) else report_mismatch("timer_irq_o", 0, timer_irq_o);

    // Timer bad offset
    bus_write(timer_base | 32'h10, 4'hF, 32'h0, err);
    assert (err === 1'b1) else report_mismatch("host_err_o", 1, err);
    bus_read(timer_base | 32'h10, rdata, err);
    assert (err === 1'b1) else report_mismatch("host_err_o", 1, err);
    check_read(timer_addr(timer_reg_mtimecmp_lo), target[31:0], "mtimecmp_lo");
    check_read(timer_addr(timer_reg_mtimecmp_hi), 32'hFFFF_FFFF, "mtimecmp_hi");

    // Halt stays up across more traffic
    assert (halt_o === 1'b0) else report_mismatch("halt_o", 0, halt_o);
    write_ok(sim_ctrl_addr(sim_ctrl_halt_off), 4'hF, 32'h1);
    assert (halt_o === 1'b1) else report_mismatch("halt_o", 1, halt_o);
    check_ram_contents();
    assert (halt_o === 1'b1) else report_mismatch("halt_o", 1, halt_o);

    $display("Test OK");
    $finish;
  end

endmodule

//--- simple_system.sv
/*
 * Simple system top level
 * Host data port, address decoder, RAM, simulation control and timer
 */
module simple_system (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     host_req_i,
  output logic                                     host_gnt_o,
  input  logic [simple_system_pkg::addr_width-1:0] host_addr_i,
  input  logic                                     host_we_i,
  input  logic [simple_system_pkg::be_width-1:0]   host_be_i,
  input  logic [simple_system_pkg::data_width-1:0] host_wdata_i,
  output logic                                     host_rvalid_o,
  output logic [simple_system_pkg::data_width-1:0] host_rdata_o,
  output logic                                     host_err_o,
  output logic                                     timer_irq_o,
  output logic                                     char_valid_o,
  output logic [7:0]                               char_o,
  output logic                                     halt_o
);

  import simple_system_pkg::*;

  // One link per device
  dev_bus_if dev_bus [nr_devices] ();

  bus_decode u_bus_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_o         (dev_bus)
  );

  ram_1p #(
    .depth (ram_depth)
  ) u_ram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (dev_bus[dev_ram])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .bus_i        (dev_bus[dev_sim_ctrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bus_i       (dev_bus[dev_timer]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- timer.sv
/*
 * Machine timer
 * 64-bit mtime and mtimecmp with a registered level interrupt
 */
module timer (
  input  logic      clk_i,
  input  logic      arst_n_i,
  dev_bus_if.device bus_i,
  output logic      timer_irq_o
);

  import simple_system_pkg::*;

  logic [dev_off_width-1:0] offset;
  logic                     wr;
  logic                     known;
  logic [63:0]              mtime_q;
  logic [63:0]              mtime_d;
  logic [63:0]              mtimecmp_q;
  logic [63:0]              mtimecmp_d;
  logic [data_width-1:0]    rdata_d;
  logic [data_width-1:0]    rdata_q;
  logic                     rvalid_q;
  logic                     err_q;
  logic                     irq_q;

  // Replace only the enabled bytes of a half
  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [be_width-1:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < be_width; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign offset = bus_i.addr[dev_off_width-1:0];
  assign wr     = bus_i.req & bus_i.we;

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    rdata_d    = '0;
    known      = 1'b1;
    case (offset)
      timer_reg_mtime_lo: begin
        rdata_d = mtime_q[31:0];
        if (wr) begin
          mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], bus_i.wdata, bus_i.be)};
        end
      end
      timer_reg_mtime_hi: begin
        rdata_d = mtime_q[63:32];
        if (wr) begin
          mtime_d = {merge_bytes(mtime_q[63:32], bus_i.wdata, bus_i.be), mtime_q[31:0]};
        end
      end
      timer_reg_mtimecmp_lo: begin
        rdata_d = mtimecmp_q[31:0];
        if (wr) begin
          mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], bus_i.wdata, bus_i.be);
        end
      end
      timer_reg_mtimecmp_hi: begin
        rdata_d = mtimecmp_q[63:32];
        if (wr) begin
          mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], bus_i.wdata, bus_i.be);
        end
      end
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_q   <= bus_i.req;
      err_q      <= bus_i.req & ~known;
      irq_q      <= mtime_q >= mtimecmp_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;
  assign timer_irq_o  = irq_q;

endmodule

//--- sim_ctrl.sv
/*
 * Simulation control device
 * Character output strobe and a sticky halt flag
 */
module sim_ctrl (
  input  logic       clk_i,
  input  logic       arst_n_i,
  dev_bus_if.device  bus_i,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  import simple_system_pkg::*;

  logic [dev_off_width-1:0] offset;
  logic                     wr;
  logic                     char_wr;
  logic                     halt_wr;
  logic                     rvalid_q;
  logic                     char_valid_q;
  logic [7:0]               char_q;
  logic                     halt_q;

  assign offset  = bus_i.addr[dev_off_width-1:0];
  assign wr      = bus_i.req & bus_i.we;
  assign char_wr = wr & (offset == sim_ctrl_char_off) & bus_i.be[0];
  assign halt_wr = wr & (offset == sim_ctrl_halt_off) & bus_i.wdata[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q     <= 1'b0;
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      rvalid_q     <= bus_i.req;
      char_valid_q <= char_wr;
      // Only reset clears halt
      if (halt_wr) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_q <= bus_i.wdata[7:0];
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  // Nothing readable here
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = '0;
  assign bus_i.err    = 1'b0;

endmodule

//--- ram_1p.sv
/*
 * Single-port RAM
 * Word RAM with byte-enabled writes and a one-cycle read response
 */
module ram_1p #(
  parameter int unsigned depth = simple_system_pkg::ram_depth
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  dev_bus_if.device bus_i
);

  import simple_system_pkg::*;

  localparam int unsigned idx_width = $clog2(depth);

  logic [data_width-1:0] mem [depth];
  logic [idx_width-1:0]  word_idx;
  logic [data_width-1:0] rdata_q;
  logic                  rvalid_q;

  // Word address, byte offset dropped
  assign word_idx = bus_i.addr[idx_width+1:2];

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int b = 0; b < be_width; b++) begin
          if (bus_i.be[b]) begin
            mem[word_idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

endmodule

//--- bus_decode.sv
/*
 * Bus decoder
 * Routes the single host to one device by base and mask, muxes the response
 */
module bus_decode (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   host_req_i,
  output logic                                   host_gnt_o,
  input  logic [simple_system_pkg::addr_width-1:0] host_addr_i,
  input  logic                                   host_we_i,
  input  logic [simple_system_pkg::be_width-1:0]   host_be_i,
  input  logic [simple_system_pkg::data_width-1:0] host_wdata_i,
  output logic                                   host_rvalid_o,
  output logic [simple_system_pkg::data_width-1:0] host_rdata_o,
  output logic                                   host_err_o,
  dev_bus_if.host                                dev_o [simple_system_pkg::nr_devices]
);

  import simple_system_pkg::*;

  logic [addr_width-1:0] dev_base [nr_devices];
  logic [addr_width-1:0] dev_mask [nr_devices];
  logic [nr_devices-1:0] dev_hit;
  logic                  dev_rvalid [nr_devices];
  logic [data_width-1:0] dev_rdata [nr_devices];
  logic                  dev_err [nr_devices];
  bus_device_e           dev_sel;
  bus_device_e           dev_sel_q;
  logic                  unmapped_q;

  assign dev_base[dev_ram]      = ram_base;
  assign dev_mask[dev_ram]      = ram_mask;
  assign dev_base[dev_sim_ctrl] = sim_ctrl_base;
  assign dev_mask[dev_sim_ctrl] = sim_ctrl_mask;
  assign dev_base[dev_timer]    = timer_base;
  assign dev_mask[dev_timer]    = timer_mask;

  // No wait states, so every request is granted at once
  assign host_gnt_o = host_req_i;

  for (genvar i = 0; i < nr_devices; i++) begin : g_dev
    assign dev_hit[i]      = (host_addr_i & dev_mask[i]) == dev_base[i];
    assign dev_o[i].req    = host_req_i & dev_hit[i];
    assign dev_o[i].we     = host_we_i;
    assign dev_o[i].be     = host_be_i;
    assign dev_o[i].addr   = host_addr_i;
    assign dev_o[i].wdata  = host_wdata_i;
    assign dev_rvalid[i]   = dev_o[i].rvalid;
    assign dev_rdata[i]    = dev_o[i].rdata;
    assign dev_err[i]      = dev_o[i].err;
  end

  // Lowest matching window wins
  always_comb begin
    dev_sel = dev_ram;
    for (int i = nr_devices - 1; i >= 0; i--) begin
      if (dev_hit[i]) begin
        dev_sel = bus_device_e'(i);
      end
    end
  end

  // Remember where the response will come from
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dev_sel_q  <= dev_ram;
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= host_req_i & ~(|dev_hit);
      if (host_req_i && (|dev_hit)) begin
        dev_sel_q <= dev_sel;
      end
    end
  end

  assign host_rvalid_o = unmapped_q | dev_rvalid[dev_sel_q];
  assign host_rdata_o  = unmapped_q ? '0 : dev_rdata[dev_sel_q];
  assign host_err_o    = unmapped_q | (dev_rvalid[dev_sel_q] & dev_err[dev_sel_q]);

endmodule

//--- dev_bus_if.sv
/*
 * Device bus port
 * One request/response link between the decoder and a device
 */
interface dev_bus_if;

  import simple_system_pkg::*;

  // Request, driven by the decoder
  logic                  req;
  logic                  we;
  logic [be_width-1:0]   be;
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] wdata;

  // Response, one cycle after req
  logic                  rvalid;
  logic [data_width-1:0] rdata;
  logic                  err;

  modport host (
    output req, we, be, addr, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, we, be, addr, wdata,
    output rvalid, rdata, err
  );

endinterface

//--- simple_system_pkg.sv
/*
 * Simple system shared definitions
 * Bus widths, device indices, address map and device register offsets
 */
package simple_system_pkg;

  // Bus word geometry
  localparam int unsigned data_width = 32;
  localparam int unsigned addr_width = 32;
  localparam int unsigned be_width   = data_width / 8;

  // Device ports on the decoder
  typedef enum logic [1:0] {
    dev_ram      = 2'd0,
    dev_sim_ctrl = 2'd1,
    dev_timer    = 2'd2
  } bus_device_e;

  localparam int unsigned nr_devices = 3;

  // Address map, each window is 1 kB
  localparam logic [addr_width-1:0] ram_base      = 32'h0010_0000;
  localparam logic [addr_width-1:0] ram_mask      = 32'hFFFF_FC00;
  localparam logic [addr_width-1:0] sim_ctrl_base = 32'h0002_0000;
  localparam logic [addr_width-1:0] sim_ctrl_mask = 32'hFFFF_FC00;
  localparam logic [addr_width-1:0] timer_base    = 32'h0003_0000;
  localparam logic [addr_width-1:0] timer_mask    = 32'hFFFF_FC00;

  // Offset bits inside one device window
  localparam int unsigned dev_off_width = 10;

  localparam int unsigned ram_depth = 256;

  // Timer registers
  localparam logic [dev_off_width-1:0] timer_reg_mtime_lo    = 10'h000;
  localparam logic [dev_off_width-1:0] timer_reg_mtime_hi    = 10'h004;
  localparam logic [dev_off_width-1:0] timer_reg_mtimecmp_lo = 10'h008;
  localparam logic [dev_off_width-1:0] timer_reg_mtimecmp_hi = 10'h00C;

  // Simulation control registers
  localparam logic [dev_off_width-1:0] sim_ctrl_char_off = 10'h000;
  localparam logic [dev_off_width-1:0] sim_ctrl_halt_off = 10'h008;

endpackage
